// ==== Bender.yml ====
package:
  name: z8core

sources:
  - hdl/z8Pkg.sv
  - hdl/z8Decoder.sv
  - hdl/z8Alu.sv
  - hdl/z8RegisterFile.sv
  - hdl/z8Sequencer.sv
  - hdl/z8Core.sv
  - target: test
    files:
      - bench/z8Core_properties.sv
      - bench/z8CoreTb.sv

// ==== bench/z8CoreTb.sv ====
module z8CoreTb import z8Pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic clk = 1'b0;
    logic arstN;
    logic wbCyc;
    logic wbStb;
    addrT wbAdr;
    byteT wbDatI = 8'h00;
    logic wbAck = 1'b0;
    logic retireValid;
    logic retireWrite;
    regAddrT retireReg;
    byteT retireData;
    flagsT retireFlags;

    byteT mem [65536];
    integer seed = 70727;
    int waitLeft = 0;

    addrT loadAdr;
    nibbleT modelRp;
    flagsT modelFlags;
    byteT modelRegs [256];

    // Retires still expected, in program order
    logic expWrite [$];
    regAddrT expReg [$];
    byteT expData [$];
    flagsT expFlags [$];

    z8Core dut_i (
        .clk(clk),
        .arstN(arstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAdr(wbAdr),
        .wbDatI(wbDatI),
        .wbAck(wbAck),
        .retireValid(retireValid),
        .retireWrite(retireWrite),
        .retireReg(retireReg),
        .retireData(retireData),
        .retireFlags(retireFlags)
    );

    always #10 clk = ~clk;

    // Memory slave, registered ack after 0 to 2 random wait cycles
    always @(posedge clk) begin
        if (!arstN || wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitLeft == 0) begin
                wbAck <= 1'b1;
                wbDatI <= mem[wbAdr];
                waitLeft <= {$random(seed)} % 3;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    // A failed bus or retire property ends the run at once
    always @(negedge clk) begin
        if (dut_i.props_i.failCount != 0) begin
            stopWithError("a bus or retire assertion failed");
        end
    end

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopWithError($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkByte(input string name, input byteT got, input byteT exp);
        if (got !== exp) begin
            stopWithError($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkRegAddr(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            stopWithError($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkFlags(input string name, input flagsT got, input flagsT exp);
        if (got !== exp) begin
            stopWithError($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp) begin
            stopWithError($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic waitRetire();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                stopWithError("timed out waiting for an instruction to retire");
            end
        end while (!retireValid);
    endtask

    task automatic waitStrobe();
        int cycles;
        cycles = 0;
        while (!wbStb) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                stopWithError("timed out waiting for a fetch on the bus");
            end
        end
    endtask

    task automatic emit(input byteT b);
        mem[loadAdr] = b;
        loadAdr++;
    endtask

    task automatic emit2(input byteT b0, input byteT b1);
        emit(b0);
        emit(b1);
    endtask

    // jr always back onto itself
    task automatic park();
        emit2(8'h8B, 8'hFE);
    endtask

    task automatic expectRetire(input logic w, input regAddrT ra, input byteT d, input flagsT f);
        expWrite.push_back(w);
        expReg.push_back(ra);
        expData.push_back(d);
        expFlags.push_back(f);
    endtask

    task automatic checkRetires();
        logic w;
        regAddrT ra;
        byteT d;
        flagsT f;
        while (expWrite.size() > 0) begin
            w = expWrite.pop_front();
            ra = expReg.pop_front();
            d = expData.pop_front();
            f = expFlags.pop_front();
            waitRetire();
            checkBit("retireWrite", retireWrite, w);
            if (w) begin
                checkRegAddr("retireReg", retireReg, ra);
                checkByte("retireData", retireData, d);
            end
            checkFlags("retireFlags", retireFlags, f);
        end
    endtask

    task automatic startProgram();
        @(posedge clk);
        arstN <= 1'b0;
        @(negedge clk);
        loadAdr = ResetPc;
        modelRp = 4'h0;
        modelFlags = 8'h00;
    endtask

    task automatic runProgram();
        park();
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic setPointer(input nibbleT p);
        emit2(8'h31, {p, 4'h0});
        modelRp = p;
        expectRetire(1'b0, 8'h00, 8'h00, modelFlags);
    endtask

    task automatic loadImm(input nibbleT r, input byteT v);
        emit2({r, 4'hC}, v);
        modelRegs[{modelRp, r}] = v;
        expectRetire(1'b1, {modelRp, r}, v, modelFlags);
    endtask

    task automatic carryOp(input byteT opc);
        emit(opc);
        case (opc)
            8'hDF: modelFlags[FlagC] = 1'b1;
            8'hCF: modelFlags[FlagC] = 1'b0;
            8'hEF: modelFlags[FlagC] = ~modelFlags[FlagC];
            default: modelFlags = modelFlags;
        endcase
        expectRetire(1'b0, 8'h00, 8'h00, modelFlags);
    endtask

    task automatic aluRegReg(input nibbleT op, input nibbleT d, input nibbleT s);
        byteT a;
        byteT b;
        byteT r;
        int full;
        int signedFull;
        int cin;
        logic writes;
        a = modelRegs[{modelRp, d}];
        b = modelRegs[{modelRp, s}];
        cin = (op == 4'h1 || op == 4'h3) ? int'(modelFlags[FlagC]) : 0;
        writes = !(op == 4'h6 || op == 4'h7 || op == 4'hA);
        signedFull = 0;
        emit2({op, 4'h2}, {d, s});
        case (op)
            4'h0, 4'h1: begin
                full = int'(a) + int'(b) + cin;
                signedFull = int'($signed(a)) + int'($signed(b)) + cin;
            end
            4'h2, 4'h3, 4'hA: begin
                full = int'(a) - int'(b) - cin;
                signedFull = int'($signed(a)) - int'($signed(b)) - cin;
            end
            4'h4: full = a | b;
            4'h5, 4'h7: full = a & b;
            4'h6: full = ~a & b;
            default: full = a ^ b;
        endcase
        r = full[7:0];
        if (op <= 4'h3 || op == 4'hA) begin
            modelFlags[FlagC] = (full < 0) || (full > 255);
            modelFlags[FlagV] = (signedFull < -128) || (signedFull > 127);
        end else begin
            modelFlags[FlagV] = 1'b0;
        end
        modelFlags[FlagZ] = (r == 8'h00);
        modelFlags[FlagS] = r[7];
        if (writes) begin
            modelRegs[{modelRp, d}] = r;
        end
        expectRetire(writes, {modelRp, d}, r, modelFlags);
    endtask

    function automatic logic condMet(input nibbleT cc, input flagsT f);
        logic base;
        case (cc[2:0])
            3'd0: base = 1'b0;
            3'd1: base = f[FlagS] ^ f[FlagV];
            3'd2: base = (f[FlagS] ^ f[FlagV]) | f[FlagZ];
            3'd3: base = f[FlagC] | f[FlagZ];
            3'd4: base = f[FlagV];
            3'd5: base = f[FlagS];
            3'd6: base = f[FlagZ];
            default: base = f[FlagC];
        endcase
        return cc[3] ? !base : base;
    endfunction

    task automatic pointerAndLoad();
        int i;
        startProgram();
        for (i = 0; i < 5; i++) begin
            setPointer(nibbleT'($random(seed) & 7));
            loadImm(nibbleT'($random(seed)), byteT'($random(seed)));
        end
        runProgram();
        checkRetires();
    endtask

    task automatic writingAluOps();
        nibbleT ops [7] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hB};
        int round;
        int i;
        startProgram();
        setPointer(4'h2);
        for (round = 0; round < 3; round++) begin
            for (i = 0; i < 7; i++) begin
                loadImm(4'h1, byteT'($random(seed)));
                loadImm(4'h2, byteT'($random(seed)));
                aluRegReg(ops[i], 4'h1, 4'h2);
            end
        end
        runProgram();
        checkRetires();
    endtask

    task automatic compareAndTestOps();
        nibbleT ops [3] = '{4'hA, 4'h7, 4'h6};
        int round;
        int i;
        startProgram();
        setPointer(4'h5);
        for (round = 0; round < 3; round++) begin
            for (i = 0; i < 3; i++) begin
                loadImm(4'h3, byteT'($random(seed)));
                loadImm(4'h4, byteT'($random(seed)));
                aluRegReg(ops[i], 4'h3, 4'h4);
                // or with a zero register reads the destination back
                loadImm(4'h6, 8'h00);
                aluRegReg(4'h4, 4'h3, 4'h6);
            end
        end
        runProgram();
        checkRetires();
    endtask

    task automatic conditionalJumps();
        nibbleT aluPick [5] = '{4'h0, 4'h2, 4'h4, 4'h5, 4'hB};
        byteT carryPick [4] = '{8'hDF, 8'hCF, 8'hEF, 8'hFF};
        int kind;
        int cc;
        logic taken;
        byteT disp;
        addrT target;
        addrT fall;
        for (kind = 0; kind < 2; kind++) begin
            for (cc = 0; cc < 16; cc++) begin
                startProgram();
                loadImm(4'h0, byteT'($random(seed)));
                loadImm(4'h1, byteT'($random(seed)));
                aluRegReg(aluPick[{$random(seed)} % 5], 4'h0, 4'h1);
                carryOp(carryPick[{$random(seed)} % 4]);
                taken = condMet(cc[3:0], modelFlags);
                if (kind == 0) begin
                    disp = byteT'(8'h04 + ($random(seed) & 8'h3F));
                    emit2({cc[3:0], 4'hB}, disp);
                    fall = loadAdr;
                    target = fall + {8'h00, disp};
                end else begin
                    target = addrT'(16'h1000 | ($random(seed) & 16'h0FFE));
                    emit({cc[3:0], 4'hD});
                    emit2(target[15:8], target[7:0]);
                    fall = loadAdr;
                end
                expectRetire(1'b0, 8'h00, 8'h00, modelFlags);
                loadAdr = target;
                park();
                loadAdr = fall;
                runProgram();
                checkRetires();
                waitStrobe();
                checkAddr("wbAdr", wbAdr, taken ? target : fall);
            end
        end
    endtask

    task automatic djnzLoop(input byteT count);
        addrT loopStart;
        int k;
        startProgram();
        carryOp(8'hDF);
        loadImm(4'h7, count);
        loopStart = loadAdr;
        emit2(8'h7A, 8'hFE);
        runProgram();
        checkRetires();
        for (k = 1; k <= count; k++) begin
            expectRetire(1'b1, 8'h07, count - byteT'(k), modelFlags);
            checkRetires();
            waitStrobe();
            checkAddr("wbAdr", wbAdr, (k < count) ? loopStart : loopStart + 16'd2);
        end
    endtask

    initial begin
        arstN = 1'b0;
        pointerAndLoad();
        writingAluOps();
        compareAndTestOps();
        conditionalJumps();
        djnzLoop(8'd1);
        djnzLoop(8'd2 + byteT'({$random(seed)} % 6));
        if (dut_i.props_i.failCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", dut_i.props_i.failCount);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

// ==== bench/z8Core_properties.sv ====
module z8CoreProperties import z8Pkg::*; (
    input logic clk,
    input logic arstN,
    input logic wbCyc,
    input logic wbStb,
    input addrT wbAdr,
    input logic wbAck,
    input logic retireValid
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    stbWithinCyc: assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbCyc)
        else begin
            $error("wbStb high without wbCyc");
            failCount++;
        end

    // Request held with a stable address until the slave acks
    stbHeldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)))
        else begin
            $error("wbStb or wbAdr changed before wbAck");
            failCount++;
        end

    retireSingleCycle: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |=> !retireValid)
        else begin
            $error("retireValid high in two consecutive cycles");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) !arstN |-> (!wbCyc && !retireValid))
        else begin
            $error("wbCyc or retireValid high during reset");
            failCount++;
        end

endmodule

bind z8Core z8CoreProperties props_i (
    .clk(clk),
    .arstN(arstN),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbAdr(wbAdr),
    .wbAck(wbAck),
    .retireValid(retireValid)
);

// ==== hdl/z8Alu.sv ====
module z8Alu import z8Pkg::*; (
    input  aluOpT  aluOp,
    input  nibbleT condCode,
    input  byteT   operandA,
    input  byteT   operandB,
    input  flagsT  flagsIn,
    output byteT   result,
    output flagsT  flagsOut,
    output logic   branchTaken
);

    logic [8:0] sum;
    logic [8:0] diff;
    logic carryIn;
    logic addOvf;
    logic subOvf;
    logic condRaw;
    logic newC;
    logic newV;

    assign carryIn = (aluOp == aluAdc || aluOp == aluSbc) ? flagsIn[FlagC] : 1'b0;
    assign sum = {1'b0, operandA} + {1'b0, operandB} + {8'd0, carryIn};
    assign diff = {1'b0, operandA} - {1'b0, operandB} - {8'd0, carryIn};

    // Signed overflow from operand and result signs
    assign addOvf = (operandA[7] == operandB[7]) && (sum[7] != operandA[7]);
    assign subOvf = (operandA[7] != operandB[7]) && (diff[7] != operandA[7]);

    always_comb begin
        case (condCode[2:0])
            3'd0: condRaw = 1'b0;
            3'd1: condRaw = flagsIn[FlagS] ^ flagsIn[FlagV];
            3'd2: condRaw = (flagsIn[FlagS] ^ flagsIn[FlagV]) | flagsIn[FlagZ];
            3'd3: condRaw = flagsIn[FlagC] | flagsIn[FlagZ];
            3'd4: condRaw = flagsIn[FlagV];
            3'd5: condRaw = flagsIn[FlagS];
            3'd6: condRaw = flagsIn[FlagZ];
            default: condRaw = flagsIn[FlagC];
        endcase
    end

    always_comb begin
        result = operandA;
        newC = flagsIn[FlagC];
        newV = 1'b0;
        case (aluOp)
            aluAdd, aluAdc: begin
                result = sum[7:0];
                newC = sum[8];
                newV = addOvf;
            end
            aluSub, aluSbc, aluCp: begin
                result = diff[7:0];
                newC = diff[8];
                newV = subOvf;
            end
            aluOr: result = operandA | operandB;
            aluAnd, aluTm: result = operandA & operandB;
            aluTcm: result = ~operandA & operandB;
            aluXor: result = operandA ^ operandB;
            aluLoad: result = operandB;
            aluDjnz: result = operandA - 8'd1;
            aluSetC: newC = 1'b1;
            aluClrC: newC = 1'b0;
            aluCplC: newC = ~flagsIn[FlagC];
            default: result = operandA;
        endcase
    end

    always_comb begin
        flagsOut = flagsIn & 8'hF0;
        case (aluOp)
            aluAdd, aluAdc, aluSub, aluSbc, aluCp,
            aluOr, aluAnd, aluTcm, aluTm, aluXor: begin
                flagsOut[FlagC] = newC;
                flagsOut[FlagZ] = (result == 8'h00);
                flagsOut[FlagS] = result[7];
                flagsOut[FlagV] = newV;
            end
            aluSetC, aluClrC, aluCplC: flagsOut[FlagC] = newC;
            default: flagsOut = flagsIn & 8'hF0;
        endcase
    end

    assign branchTaken = (aluOp == aluJump) ? (condRaw ^ condCode[3])
                       : (aluOp == aluDjnz) ? (result != 8'h00)
                       : 1'b0;

endmodule

// ==== hdl/z8Core.sv ====
module z8Core import z8Pkg::*; (
    input  logic    clk,
    input  logic    arstN,
    output logic    wbCyc,
    output logic    wbStb,
    output addrT    wbAdr,
    input  byteT    wbDatI,
    input  logic    wbAck,
    output logic    retireValid,
    output logic    retireWrite,
    output regAddrT retireReg,
    output byteT    retireData,
    output flagsT   retireFlags
);

    byteT opcode;
    byteT operand1;
    byteT operand2;
    logic commit;
    instrLenT instrLen;
    aluOpT aluOp;
    nibbleT condCode;
    nibbleT readRegA;
    nibbleT readRegB;
    byteT immediate;
    logic useImmediate;
    logic regWrite;
    nibbleT writeReg;
    logic flagsWrite;
    logic rpWrite;
    nibbleT rpValue;
    logic jumpDirect;
    byteT dataA;
    byteT dataB;
    byteT operandB;
    byteT aluResult;
    flagsT flags;
    flagsT aluFlags;
    logic branchTaken;

    // Immediate replaces the source register for ld r,#im
    assign operandB = useImmediate ? immediate : dataB;

    z8Sequencer sequencer_i (
        .clk(clk),
        .arstN(arstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAdr(wbAdr),
        .wbDatI(wbDatI),
        .wbAck(wbAck),
        .instrLen(instrLen),
        .branchTaken(branchTaken),
        .jumpDirect(jumpDirect),
        .opcode(opcode),
        .operand1(operand1),
        .operand2(operand2),
        .commit(commit)
    );

    z8Decoder decoder_i (
        .opcode(opcode),
        .operand1(operand1),
        .operand2(operand2),
        .instrLen(instrLen),
        .aluOp(aluOp),
        .condCode(condCode),
        .readRegA(readRegA),
        .readRegB(readRegB),
        .immediate(immediate),
        .useImmediate(useImmediate),
        .regWrite(regWrite),
        .writeReg(writeReg),
        .flagsWrite(flagsWrite),
        .rpWrite(rpWrite),
        .rpValue(rpValue),
        .jumpDirect(jumpDirect)
    );

    z8Alu alu_i (
        .aluOp(aluOp),
        .condCode(condCode),
        .operandA(dataA),
        .operandB(operandB),
        .flagsIn(flags),
        .result(aluResult),
        .flagsOut(aluFlags),
        .branchTaken(branchTaken)
    );

    z8RegisterFile registerFile_i (
        .clk(clk),
        .arstN(arstN),
        .readRegA(readRegA),
        .readRegB(readRegB),
        .dataA(dataA),
        .dataB(dataB),
        .commit(commit),
        .regWrite(regWrite),
        .writeReg(writeReg),
        .writeData(aluResult),
        .flagsWrite(flagsWrite),
        .flagsIn(aluFlags),
        .flags(flags),
        .rpWrite(rpWrite),
        .rpValue(rpValue),
        .retireValid(retireValid),
        .retireWrite(retireWrite),
        .retireReg(retireReg),
        .retireData(retireData),
        .retireFlags(retireFlags)
    );

endmodule

// ==== hdl/z8Decoder.sv ====
module z8Decoder import z8Pkg::*; (
    input  byteT     opcode,
    input  byteT     operand1,
    input  byteT     operand2,
    output instrLenT instrLen,
    output aluOpT    aluOp,
    output nibbleT   condCode,
    output nibbleT   readRegA,
    output nibbleT   readRegB,
    output byteT     immediate,
    output logic     useImmediate,
    output logic     regWrite,
    output nibbleT   writeReg,
    output logic     flagsWrite,
    output logic     rpWrite,
    output nibbleT   rpValue,
    output logic     jumpDirect
);

    nibbleT opH;
    nibbleT opL;

    assign opH = opcode[7:4];
    assign opL = opcode[3:0];

    // Length depends on the low nibble only
    always_comb begin
        if (opL == 4'hE || opL == 4'hF) begin
            instrLen = len1;
        end else if (opL[3:2] == 2'b01 || opL == 4'hD) begin
            instrLen = len3;
        end else begin
            instrLen = len2;
        end
    end

    assign condCode = opH;
    assign immediate = operand1;
    assign rpValue = operand1[7:4];

    always_comb begin
        aluOp = aluNop;
        readRegA = operand1[7:4];
        readRegB = operand1[3:0];
        writeReg = operand1[7:4];
        useImmediate = 1'b0;
        regWrite = 1'b0;
        flagsWrite = 1'b0;
        rpWrite = 1'b0;
        jumpDirect = 1'b0;

        case (opL)
            4'h2: begin
                flagsWrite = 1'b1;
                regWrite = 1'b1;
                case (opH)
                    4'h0: aluOp = aluAdd;
                    4'h1: aluOp = aluAdc;
                    4'h2: aluOp = aluSub;
                    4'h3: aluOp = aluSbc;
                    4'h4: aluOp = aluOr;
                    4'h5: aluOp = aluAnd;
                    4'h6: aluOp = aluTcm;
                    4'h7: aluOp = aluTm;
                    4'hA: aluOp = aluCp;
                    4'hB: aluOp = aluXor;
                    default: begin
                        flagsWrite = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
                // Tests and compare only touch the flags
                if (opH == 4'h6 || opH == 4'h7 || opH == 4'hA) begin
                    regWrite = 1'b0;
                end
            end
            4'hC: begin
                aluOp = aluLoad;
                useImmediate = 1'b1;
                readRegA = opH;
                writeReg = opH;
                regWrite = 1'b1;
            end
            4'hA: begin
                aluOp = aluDjnz;
                readRegA = opH;
                writeReg = opH;
                regWrite = 1'b1;
            end
            4'hB: aluOp = aluJump;
            4'hD: begin
                aluOp = aluJump;
                jumpDirect = 1'b1;
            end
            default: begin
                case (opcode)
                    8'h31: rpWrite = 1'b1;
                    8'hDF: begin
                        aluOp = aluSetC;
                        flagsWrite = 1'b1;
                    end
                    8'hCF: begin
                        aluOp = aluClrC;
                        flagsWrite = 1'b1;
                    end
                    8'hEF: begin
                        aluOp = aluCplC;
                        flagsWrite = 1'b1;
                    end
                    default: aluOp = aluNop;
                endcase
            end
        endcase
    end

endmodule

// ==== hdl/z8Pkg.sv ====
package z8Pkg;

    // Basic data widths
    typedef logic [7:0] byteT;
    typedef logic [15:0] addrT;
    typedef logic [3:0] nibbleT;

    // Register pointer nibble followed by working register nibble
    typedef logic [7:0] regAddrT;

    typedef logic [7:0] flagsT;

    // Flag bit positions, low nibble always zero
    localparam int FlagC = 7;
    localparam int FlagZ = 6;
    localparam int FlagS = 5;
    localparam int FlagV = 4;

    localparam addrT ResetPc = 16'h000C;

    localparam int RegCount = 128;

    typedef enum logic [1:0] {
        len1,
        len2,
        len3
    } instrLenT;

    typedef enum logic [4:0] {
        aluAdd,
        aluAdc,
        aluSub,
        aluSbc,
        aluOr,
        aluAnd,
        aluTcm,
        aluTm,
        aluCp,
        aluXor,
        aluLoad,
        aluDjnz,
        aluJump,
        aluSetC,
        aluClrC,
        aluCplC,
        aluNop
    } aluOpT;

    // Fetch and execute sequencing
    typedef enum logic [2:0] {
        seqIdle,
        seqFetch1,
        seqFetch2,
        seqFetch3,
        seqExecute
    } seqStateT;

endpackage

// ==== hdl/z8RegisterFile.sv ====
module z8RegisterFile import z8Pkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  nibbleT  readRegA,
    input  nibbleT  readRegB,
    output byteT    dataA,
    output byteT    dataB,
    input  logic    commit,
    input  logic    regWrite,
    input  nibbleT  writeReg,
    input  byteT    writeData,
    input  logic    flagsWrite,
    input  flagsT   flagsIn,
    output flagsT   flags,
    input  logic    rpWrite,
    input  nibbleT  rpValue,
    output logic    retireValid,
    output logic    retireWrite,
    output regAddrT retireReg,
    output byteT    retireData,
    output flagsT   retireFlags
);

    byteT regs [RegCount];
    nibbleT rp;
    regAddrT addrA;
    regAddrT addrB;
    regAddrT addrW;
    logic doWrite;

    assign addrA = {rp, readRegA};
    assign addrB = {rp, readRegB};
    assign addrW = {rp, writeReg};

    // Upper half of the register space is not implemented
    assign dataA = addrA[7] ? 8'h00 : regs[addrA[6:0]];
    assign dataB = addrB[7] ? 8'h00 : regs[addrB[6:0]];

    assign doWrite = commit && regWrite && !addrW[7];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            regs[addrW[6:0]] <= writeData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
            rp <= '0;
            retireValid <= 1'b0;
            retireWrite <= 1'b0;
        end else begin
            if (commit && flagsWrite) begin
                flags <= flagsIn & 8'hF0;
            end
            if (commit && rpWrite) begin
                rp <= rpValue;
            end
            retireValid <= commit;
            retireWrite <= doWrite;
        end
    end

    // Report of the instruction just committed
    always_ff @(posedge clk) begin
        if (commit) begin
            retireReg <= addrW;
            retireData <= writeData;
            retireFlags <= flagsWrite ? (flagsIn & 8'hF0) : flags;
        end
    end

endmodule

// ==== hdl/z8Sequencer.sv ====
module z8Sequencer import z8Pkg::*; (
    input  logic     clk,
    input  logic     arstN,
    output logic     wbCyc,
    output logic     wbStb,
    output addrT     wbAdr,
    input  byteT     wbDatI,
    input  logic     wbAck,
    input  instrLenT instrLen,
    input  logic     branchTaken,
    input  logic     jumpDirect,
    output byteT     opcode,
    output byteT     operand1,
    output byteT     operand2,
    output logic     commit
);

    seqStateT state;
    addrT pc;
    addrT relTarget;
    addrT directTarget;
    logic gap;
    logic fetching;
    logic byteAck;

    assign fetching = (state == seqFetch1) || (state == seqFetch2) || (state == seqFetch3);

    // One idle bus cycle after every acknowledged byte
    assign wbStb = fetching && !gap;
    assign wbCyc = wbStb;
    assign wbAdr = pc;

    assign byteAck = wbStb && wbAck;
    assign commit = (state == seqExecute);

    // pc already points past the instruction here
    assign relTarget = pc + {{8{operand1[7]}}, operand1};
    assign directTarget = {operand1, operand2};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= seqIdle;
            pc <= ResetPc;
            gap <= 1'b0;
        end else begin
            gap <= byteAck;
            if (byteAck) begin
                pc <= pc + 16'd1;
            end
            case (state)
                seqIdle: state <= seqFetch1;
                seqFetch1: begin
                    if (byteAck) begin
                        state <= seqFetch2;
                    end
                end
                seqFetch2: begin
                    // Opcode is decoded during the gap cycle
                    if (gap && instrLen == len1) begin
                        state <= seqExecute;
                    end else if (byteAck) begin
                        state <= (instrLen == len2) ? seqExecute : seqFetch3;
                    end
                end
                seqFetch3: begin
                    if (byteAck) begin
                        state <= seqExecute;
                    end
                end
                seqExecute: begin
                    state <= seqFetch1;
                    if (branchTaken) begin
                        pc <= jumpDirect ? directTarget : relTarget;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // Instruction byte latches
    always_ff @(posedge clk) begin
        if (byteAck) begin
            case (state)
                seqFetch1: opcode <= wbDatI;
                seqFetch2: operand1 <= wbDatI;
                seqFetch3: operand2 <= wbDatI;
                default: opcode <= opcode;
            endcase
        end
    end

endmodule

// ==== z8Core.f ====
hdl/z8Pkg.sv
hdl/z8Decoder.sv
hdl/z8Alu.sv
hdl/z8RegisterFile.sv
hdl/z8Sequencer.sv
hdl/z8Core.sv
bench/z8Core_properties.sv
bench/z8CoreTb.sv
